// ==== design/spritePkg.sv ====
`default_nettype none

package spritePkg;

	// ----------------------------------------------------------
	// sizes
	// ----------------------------------------------------------
	localparam int NUM_SPRITES = 4;
	localparam int SPR_IDX_W = 2;
	// beam counters and sprite position
	localparam int H_BITS = 12;
	localparam int V_BITS = 12;
	// width-1, height-1 and pixel size-1 fields
	localparam int SIZE_W = 4;
	localparam int PLANE_W = 4;
	// RGB332 pixel, also the transparent colour
	localparam int PIX_W = 8;
	// 256 pixels per image cache
	localparam int IMG_ADR_W = 8;
	// stream word is plane plus three 12 bit channels
	localparam int ZRGB_W = 40;
	localparam int CHAN_W = 12;
	localparam int REG_ADR_W = 5;
	localparam int REG_DAT_W = 32;

	// ----------------------------------------------------------
	// register map
	// ----------------------------------------------------------
	// word offset inside a sprite's block of four
	localparam logic [1:0] REG_POS = 2'd0;
	localparam logic [1:0] REG_SIZE = 2'd1;
	localparam logic [1:0] REG_TC = 2'd2;
	// global words
	localparam logic [REG_ADR_W-1:0] REG_EN = 5'd16;
	localparam logic [REG_ADR_W-1:0] REG_IE = 5'd17;
	localparam logic [REG_ADR_W-1:0] REG_COL = 5'd18;
	localparam logic [REG_ADR_W-1:0] REG_STAT = 5'd19;

	// field positions in REG_POS and REG_SIZE
	localparam int POS_H_LSB = 0;
	localparam int POS_V_LSB = 16;
	localparam int SZ_W_LSB = 0;
	localparam int SZ_H_LSB = 8;
	localparam int SZ_HS_LSB = 16;
	localparam int SZ_VS_LSB = 20;
	localparam int SZ_PL_LSB = 24;

	// ----------------------------------------------------------
	// pipeline, one cycle per stage
	// ----------------------------------------------------------
	typedef enum logic [1:0] {MATCH, FETCH, SELECT, COMPOSE} pipeStage_e;
	localparam int PIPE_DEPTH = 4;
	// stream and blank reach the compose stage this many cycles late
	localparam int STREAM_DLY = int'(COMPOSE);

endpackage

`default_nettype wire

// ==== design/spriteRegs.sv ====
`default_nettype none

module spriteRegs (
	input  logic vclk,
	input  logic rst_i,
	input  logic regWe_i,
	input  logic regRd_i,
	input  logic [spritePkg::REG_ADR_W-1:0] regAdr_i,
	input  logic [spritePkg::REG_DAT_W-1:0] regWdata_i,
	input  logic [spritePkg::NUM_SPRITES-1:0] colBits_i,
	input  logic colPending_i,
	output logic [spritePkg::NUM_SPRITES-1:0][spritePkg::H_BITS-1:0] hPos_o,
	output logic [spritePkg::NUM_SPRITES-1:0][spritePkg::V_BITS-1:0] vPos_o,
	output logic [spritePkg::NUM_SPRITES-1:0][spritePkg::SIZE_W-1:0] width_o,
	output logic [spritePkg::NUM_SPRITES-1:0][spritePkg::SIZE_W-1:0] height_o,
	output logic [spritePkg::NUM_SPRITES-1:0][spritePkg::SIZE_W-1:0] hSize_o,
	output logic [spritePkg::NUM_SPRITES-1:0][spritePkg::SIZE_W-1:0] vSize_o,
	output logic [spritePkg::NUM_SPRITES-1:0][spritePkg::PLANE_W-1:0] plane_o,
	output logic [spritePkg::NUM_SPRITES-1:0][spritePkg::PIX_W-1:0] transColor_o,
	output logic [spritePkg::NUM_SPRITES-1:0] sprEn_o,
	output logic irqEn_o,
	output logic colClear_o,
	output logic [spritePkg::REG_DAT_W-1:0] rdData_o,
	output logic rdValid_o
);
	import spritePkg::*;

	// address split, top bit selects the global words
	logic isSprite;
	logic [SPR_IDX_W-1:0] sprIdx;
	logic [1:0] wordSel;
	logic [REG_DAT_W-1:0] rdMux;

	assign isSprite = ~regAdr_i[REG_ADR_W-1];
	assign sprIdx = regAdr_i[SPR_IDX_W+1:2];
	assign wordSel = regAdr_i[1:0];

	// ----------------------------------------------------------
	// writes, whole words only
	// ----------------------------------------------------------
	always_ff @(posedge vclk) begin
		if (rst_i) begin
			hPos_o <= '0;
			vPos_o <= '0;
			width_o <= '0;
			height_o <= '0;
			hSize_o <= '0;
			vSize_o <= '0;
			plane_o <= '0;
			transColor_o <= '0;
			sprEn_o <= '0;
			irqEn_o <= 1'b0;
		end else if (regWe_i) begin
			if (isSprite) begin
				case (wordSel)
					REG_POS: begin
						hPos_o[sprIdx] <= regWdata_i[POS_H_LSB +: H_BITS];
						vPos_o[sprIdx] <= regWdata_i[POS_V_LSB +: V_BITS];
					end
					REG_SIZE: begin
						width_o[sprIdx] <= regWdata_i[SZ_W_LSB +: SIZE_W];
						height_o[sprIdx] <= regWdata_i[SZ_H_LSB +: SIZE_W];
						hSize_o[sprIdx] <= regWdata_i[SZ_HS_LSB +: SIZE_W];
						vSize_o[sprIdx] <= regWdata_i[SZ_VS_LSB +: SIZE_W];
						plane_o[sprIdx] <= regWdata_i[SZ_PL_LSB +: PLANE_W];
					end
					REG_TC: transColor_o[sprIdx] <= regWdata_i[PIX_W-1:0];
					// word 3 reserved
					default: ;
				endcase
			end else begin
				case (regAdr_i)
					REG_EN: sprEn_o <= regWdata_i[NUM_SPRITES-1:0];
					REG_IE: irqEn_o <= regWdata_i[0];
					// collision and status are read only
					default: ;
				endcase
			end
		end
	end

	// ----------------------------------------------------------
	// read mux, unused bits and unmapped words are zero
	// ----------------------------------------------------------
	always_comb begin
		rdMux = '0;
		if (isSprite) begin
			case (wordSel)
				REG_POS: begin
					rdMux[POS_H_LSB +: H_BITS] = hPos_o[sprIdx];
					rdMux[POS_V_LSB +: V_BITS] = vPos_o[sprIdx];
				end
				REG_SIZE: begin
					rdMux[SZ_W_LSB +: SIZE_W] = width_o[sprIdx];
					rdMux[SZ_H_LSB +: SIZE_W] = height_o[sprIdx];
					rdMux[SZ_HS_LSB +: SIZE_W] = hSize_o[sprIdx];
					rdMux[SZ_VS_LSB +: SIZE_W] = vSize_o[sprIdx];
					rdMux[SZ_PL_LSB +: PLANE_W] = plane_o[sprIdx];
				end
				REG_TC: rdMux[PIX_W-1:0] = transColor_o[sprIdx];
				default: ;
			endcase
		end else begin
			case (regAdr_i)
				REG_EN: rdMux[NUM_SPRITES-1:0] = sprEn_o;
				REG_IE: rdMux[0] = irqEn_o;
				REG_COL: rdMux[NUM_SPRITES-1:0] = colBits_i;
				REG_STAT: rdMux[0] = colPending_i;
				default: ;
			endcase
		end
	end

	// clear lands on the same edge that samples the bits,
	// so a collision in that cycle is never lost
	assign colClear_o = regRd_i && (regAdr_i == REG_COL);

	// fixed one cycle read latency
	always_ff @(posedge vclk) begin
		if (rst_i) begin
			rdValid_o <= 1'b0;
		end else begin
			rdValid_o <= regRd_i;
		end
	end

	always_ff @(posedge vclk) begin
		if (regRd_i) begin
			rdData_o <= rdMux;
		end
	end

endmodule

`default_nettype wire

// ==== design/spriteImageRam.sv ====
`default_nettype none

module spriteImageRam (
	input  logic vclk,
	input  logic we_i,
	input  logic [spritePkg::IMG_ADR_W-1:0] wAdr_i,
	input  logic [spritePkg::PIX_W-1:0] wDat_i,
	input  logic [spritePkg::IMG_ADR_W-1:0] rAdr_i,
	output logic [spritePkg::PIX_W-1:0] rDat_o
);
	import spritePkg::*;

	// one RGB332 pixel per entry
	logic [PIX_W-1:0] mem [2**IMG_ADR_W];

	// host image port
	always_ff @(posedge vclk) begin
		if (we_i) begin
			mem[wAdr_i] <= wDat_i;
		end
	end

	// FETCH stage, registered read for the display side
	always_ff @(posedge vclk) begin
		rDat_o <= mem[rAdr_i];
	end

endmodule

`default_nettype wire

// ==== design/spriteEngine.sv ====
`default_nettype none

module spriteEngine (
	input  logic vclk,
	input  logic rst_i,
	input  logic [spritePkg::H_BITS-1:0] hctr_i,
	input  logic [spritePkg::V_BITS-1:0] vctr_i,
	input  logic hStart_i,
	input  logic [spritePkg::H_BITS-1:0] hPos_i,
	input  logic [spritePkg::V_BITS-1:0] vPos_i,
	input  logic [spritePkg::SIZE_W-1:0] width_i,
	input  logic [spritePkg::SIZE_W-1:0] height_i,
	input  logic [spritePkg::SIZE_W-1:0] hSize_i,
	input  logic [spritePkg::SIZE_W-1:0] vSize_i,
	output logic [spritePkg::IMG_ADR_W-1:0] ramAdr_o,
	output logic de_o
);
	import spritePkg::*;

	logic hMatch;
	logic vMatch;
	logic lineBlank;
	logic hNext;
	logic vNext;
	logic [IMG_ADR_W-1:0] widthPix;
	// state left by the previous pixel or line
	logic [SIZE_W-1:0] hPt;
	logic [SIZE_W-1:0] vPt;
	logic [SIZE_W-1:0] colCnt;
	logic [SIZE_W-1:0] rowCnt;
	logic hDe;
	logic vDe;
	logic [IMG_ADR_W-1:0] rowBase;
	// state for the pixel in this cycle
	logic [SIZE_W-1:0] hPtCur;
	logic [SIZE_W-1:0] vPtCur;
	logic [SIZE_W-1:0] colCur;
	logic [SIZE_W-1:0] rowCur;
	logic hDeCur;
	logic vDeCur;
	logic [IMG_ADR_W-1:0] rowBaseCur;
	logic [IMG_ADR_W-1:0] adrCur;

	assign hMatch = hctr_i == hPos_i;
	assign vMatch = vctr_i == vPos_i;
	// line -1, between vsync and the first hsync
	assign lineBlank = &vctr_i;
	// pixel size toggles wrap here
	assign hNext = hPt == hSize_i;
	assign vNext = vPt == vSize_i;
	assign widthPix = {{(IMG_ADR_W-SIZE_W){1'b0}}, width_i} + 1'b1;

	// ----------------------------------------------------------
	// vertical, steps once per line at hStart
	// ----------------------------------------------------------
	always_comb begin
		vPtCur = vPt;
		rowCur = rowCnt;
		vDeCur = vDe;
		rowBaseCur = rowBase;
		if (hStart_i) begin
			if (vMatch) begin
				vPtCur = '0;
				rowCur = '0;
				vDeCur = 1'b1;
				rowBaseCur = '0;
			end else if (vNext) begin
				// next image row, backup address moves on one row
				vPtCur = '0;
				rowCur = rowCnt + 1'b1;
				vDeCur = vDe & (rowCnt != height_i);
				rowBaseCur = rowBase + widthPix;
			end else begin
				// repeat the row, rescan from the backup address
				vPtCur = vPt + 1'b1;
			end
		end
		if (lineBlank) begin
			vDeCur = 1'b0;
		end
	end

	// ----------------------------------------------------------
	// horizontal, steps every clock
	// ----------------------------------------------------------
	always_comb begin
		hPtCur = hNext ? '0 : hPt + 1'b1;
		colCur = hNext ? colCnt + 1'b1 : colCnt;
		hDeCur = hDe & ~(hNext & (colCnt == width_i));
		// address advances with each new horizontal pixel
		adrCur = hNext ? ramAdr_o + 1'b1 : ramAdr_o;
		if (hMatch) begin
			hPtCur = '0;
			colCur = '0;
			hDeCur = 1'b1;
			adrCur = rowBaseCur;
		end else if (hStart_i) begin
			// a sprite never wraps onto the next line
			hDeCur = 1'b0;
		end
	end

	// MATCH stage registers
	always_ff @(posedge vclk) begin
		if (rst_i) begin
			hPt <= '0;
			vPt <= '0;
			colCnt <= '0;
			rowCnt <= '0;
			hDe <= 1'b0;
			vDe <= 1'b0;
			rowBase <= '0;
			ramAdr_o <= '0;
			de_o <= 1'b0;
		end else begin
			hPt <= hPtCur;
			vPt <= vPtCur;
			colCnt <= colCur;
			rowCnt <= rowCur;
			hDe <= hDeCur;
			vDe <= vDeCur;
			rowBase <= rowBaseCur;
			ramAdr_o <= adrCur;
			de_o <= hDeCur & vDeCur;
		end
	end

endmodule

`default_nettype wire

// ==== design/spriteCompositor.sv ====
`default_nettype none

module spriteCompositor (
	input  logic vclk,
	input  logic rst_i,
	input  logic [spritePkg::NUM_SPRITES-1:0][spritePkg::PIX_W-1:0] pix_i,
	input  logic [spritePkg::NUM_SPRITES-1:0] de_i,
	input  logic [spritePkg::NUM_SPRITES-1:0] sprEn_i,
	input  logic [spritePkg::NUM_SPRITES-1:0][spritePkg::PIX_W-1:0] transColor_i,
	input  logic [spritePkg::NUM_SPRITES-1:0][spritePkg::PLANE_W-1:0] plane_i,
	input  logic irqEn_i,
	input  logic colClear_i,
	input  logic [spritePkg::ZRGB_W-1:0] zrgbDly_i,
	input  logic blankDly_i,
	output logic [spritePkg::ZRGB_W-1:0] zrgb_o,
	output logic [spritePkg::NUM_SPRITES-1:0] colBits_o,
	output logic colPending_o,
	output logic irq_o
);
	import spritePkg::*;

	// de held one stage to meet the RAM data
	logic [NUM_SPRITES-1:0] deDly;
	logic [NUM_SPRITES-1:0] actNow;
	logic [PIX_W-1:0] winPixNow;
	logic [PLANE_W-1:0] winPlaneNow;
	// SELECT stage registers
	logic [NUM_SPRITES-1:0] act;
	logic [PIX_W-1:0] winPix;
	logic [PLANE_W-1:0] winPlane;
	logic multiHit;
	logic [PLANE_W-1:0] inPlane;
	logic [ZRGB_W-1:0] sprZrgb;

	always_ff @(posedge vclk) begin
		if (rst_i) begin
			deDly <= '0;
		end else begin
			deDly <= de_i;
		end
	end

	// ----------------------------------------------------------
	// SELECT, transparency and fixed priority
	// ----------------------------------------------------------
	always_comb begin
		winPixNow = '0;
		winPlaneNow = '0;
		// walk from the top so sprite 0 is taken last and wins
		for (int i = NUM_SPRITES - 1; i >= 0; i--) begin
			actNow[i] = sprEn_i[i] & deDly[i] & (pix_i[i] != transColor_i[i]);
			if (actNow[i]) begin
				winPixNow = pix_i[i];
				winPlaneNow = plane_i[i];
			end
		end
	end

	always_ff @(posedge vclk) begin
		if (rst_i) begin
			act <= '0;
		end else begin
			act <= actNow;
		end
	end

	always_ff @(posedge vclk) begin
		winPix <= winPixNow;
		winPlane <= winPlaneNow;
	end

	// ----------------------------------------------------------
	// COMPOSE, plane test, RGB332 expansion, blanking
	// ----------------------------------------------------------
	assign inPlane = zrgbDly_i[ZRGB_W-1 -: PLANE_W];
	// each field sits at the top of its channel
	assign sprZrgb = {winPlane,
		winPix[7:5], {(CHAN_W-3){1'b0}},
		winPix[4:2], {(CHAN_W-3){1'b0}},
		winPix[1:0], {(CHAN_W-2){1'b0}}};

	always_ff @(posedge vclk) begin
		if (blankDly_i) begin
			zrgb_o <= '0;
		end else if (|act && (inPlane <= winPlane)) begin
			zrgb_o <= sprZrgb;
		end else begin
			// no sprite, or the stream is in front
			zrgb_o <= zrgbDly_i;
		end
	end

	// ----------------------------------------------------------
	// sprite to sprite collision
	// ----------------------------------------------------------
	// two or more bits set
	assign multiHit = |(act & (act - 1'b1));

	always_ff @(posedge vclk) begin
		if (rst_i) begin
			colBits_o <= '0;
			colPending_o <= 1'b0;
		end else if (multiHit) begin
			// a hit in the clearing cycle starts a fresh set
			colBits_o <= colClear_i ? act : (colBits_o | act);
			colPending_o <= 1'b1;
		end else if (colClear_i) begin
			colBits_o <= '0;
			colPending_o <= 1'b0;
		end
	end

	assign irq_o = colPending_o & irqEn_i;

endmodule

`default_nettype wire

// ==== design/spriteController.sv ====
`default_nettype none

module spriteController (
	input  logic vclk,
	input  logic rst_i,
	input  logic hsync_i,
	input  logic vsync_i,
	input  logic blank_i,
	input  logic [spritePkg::ZRGB_W-1:0] zrgb_i,
	output logic [spritePkg::ZRGB_W-1:0] zrgb_o,
	input  logic regWe_i,
	input  logic regRd_i,
	input  logic [spritePkg::REG_ADR_W-1:0] regAdr_i,
	input  logic [spritePkg::REG_DAT_W-1:0] regWdata_i,
	output logic [spritePkg::REG_DAT_W-1:0] rdData_o,
	output logic rdValid_o,
	input  logic imgWe_i,
	input  logic [spritePkg::SPR_IDX_W-1:0] imgSprite_i,
	input  logic [spritePkg::IMG_ADR_W-1:0] imgAdr_i,
	input  logic [spritePkg::PIX_W-1:0] imgDat_i,
	output logic irq_o
);
	import spritePkg::*;

	logic hsyncD;
	logic vsyncD;
	logic hStart;
	logic vStart;
	logic [H_BITS-1:0] hctr;
	logic [H_BITS-1:0] hctrReg;
	logic [V_BITS-1:0] vctr;
	logic [V_BITS-1:0] vctrReg;
	logic [V_BITS-1:0] vBase;
	// register fields
	logic [NUM_SPRITES-1:0][H_BITS-1:0] hPos;
	logic [NUM_SPRITES-1:0][V_BITS-1:0] vPos;
	logic [NUM_SPRITES-1:0][SIZE_W-1:0] width;
	logic [NUM_SPRITES-1:0][SIZE_W-1:0] height;
	logic [NUM_SPRITES-1:0][SIZE_W-1:0] hSize;
	logic [NUM_SPRITES-1:0][SIZE_W-1:0] vSize;
	logic [NUM_SPRITES-1:0][PLANE_W-1:0] plane;
	logic [NUM_SPRITES-1:0][PIX_W-1:0] transColor;
	logic [NUM_SPRITES-1:0] sprEn;
	logic irqEn;
	logic colClear;
	logic [NUM_SPRITES-1:0] colBits;
	logic colPending;
	// per sprite pipeline
	logic [NUM_SPRITES-1:0][IMG_ADR_W-1:0] ramAdr;
	logic [NUM_SPRITES-1:0] de;
	logic [NUM_SPRITES-1:0][PIX_W-1:0] pix;
	// stream alignment
	logic [ZRGB_W-1:0] zrgbPipe [STREAM_DLY];
	logic [STREAM_DLY-1:0] blankPipe;

	// ----------------------------------------------------------
	// beam counters, x and y valid in the edge cycle itself
	// ----------------------------------------------------------
	assign hStart = hsync_i & ~hsyncD;
	assign vStart = vsync_i & ~vsyncD;
	assign hctr = hStart ? '0 : hctrReg + 1'b1;
	// vsync puts y at -1, the first hsync makes it 0
	assign vBase = vStart ? '1 : vctrReg;
	assign vctr = hStart ? vBase + 1'b1 : vBase;

	always_ff @(posedge vclk) begin
		if (rst_i) begin
			hsyncD <= 1'b0;
			vsyncD <= 1'b0;
			hctrReg <= '0;
			vctrReg <= '0;
		end else begin
			hsyncD <= hsync_i;
			vsyncD <= vsync_i;
			hctrReg <= hctr;
			vctrReg <= vctr;
		end
	end

	// stream and blank wait for MATCH, FETCH and SELECT
	always_ff @(posedge vclk) begin
		zrgbPipe[0] <= zrgb_i;
		for (int i = 1; i < STREAM_DLY; i++) begin
			zrgbPipe[i] <= zrgbPipe[i-1];
		end
		blankPipe <= {blankPipe[STREAM_DLY-2:0], blank_i};
	end

	spriteRegs spriteRegs_i (
		.vclk, .rst_i, .regWe_i, .regRd_i, .regAdr_i, .regWdata_i,
		.colBits_i(colBits), .colPending_i(colPending),
		.hPos_o(hPos), .vPos_o(vPos), .width_o(width), .height_o(height),
		.hSize_o(hSize), .vSize_o(vSize), .plane_o(plane),
		.transColor_o(transColor), .sprEn_o(sprEn), .irqEn_o(irqEn),
		.colClear_o(colClear), .rdData_o, .rdValid_o
	);

	// one engine and one image cache per sprite
	for (genvar g = 0; g < NUM_SPRITES; g++) begin : genSprite
		spriteEngine spriteEngine_i (
			.vclk, .rst_i, .hctr_i(hctr), .vctr_i(vctr), .hStart_i(hStart),
			.hPos_i(hPos[g]), .vPos_i(vPos[g]), .width_i(width[g]),
			.height_i(height[g]), .hSize_i(hSize[g]), .vSize_i(vSize[g]),
			.ramAdr_o(ramAdr[g]), .de_o(de[g])
		);
		// image port write enable decoded per cache
		spriteImageRam spriteImageRam_i (
			.vclk, .we_i(imgWe_i && (imgSprite_i == g)), .wAdr_i(imgAdr_i),
			.wDat_i(imgDat_i), .rAdr_i(ramAdr[g]), .rDat_o(pix[g])
		);
	end

	spriteCompositor spriteCompositor_i (
		.vclk, .rst_i, .pix_i(pix), .de_i(de), .sprEn_i(sprEn),
		.transColor_i(transColor), .plane_i(plane), .irqEn_i(irqEn),
		.colClear_i(colClear), .zrgbDly_i(zrgbPipe[STREAM_DLY-1]),
		.blankDly_i(blankPipe[STREAM_DLY-1]), .zrgb_o,
		.colBits_o(colBits), .colPending_o(colPending), .irq_o
	);

endmodule

`default_nettype wire

// ==== verification/spriteController_chk.sv ====
`default_nettype none

module spriteControllerChk (
	input  logic vclk,
	input  logic rst_i,
	input  logic regRd_i,
	input  logic rdValid_i,
	input  logic irq_i,
	input  logic irqEn_i,
	input  logic [spritePkg::NUM_SPRITES-1:0] colBits_i,
	input  logic blank_i,
	input  logic [spritePkg::ZRGB_W-1:0] zrgb_i
);
	timeunit 1ns;
	timeprecision 1ps;
	import spritePkg::*;

	// number of failed properties
	int failCount = 0;

	// ----------------------------------------------------------
	// host read port with a fixed one cycle latency
	// ----------------------------------------------------------
	assert property (@(posedge vclk) disable iff (rst_i) regRd_i |=> rdValid_i)
	else begin
		failCount++;
		$error("rdValid_o missing one cycle after regRd_i");
	end

	assert property (@(posedge vclk) disable iff (rst_i) !regRd_i |=> !rdValid_i)
	else begin
		failCount++;
		$error("rdValid_o high without a read one cycle before");
	end

	// interrupt needs the enable bit and a collision of two or more sprites
	assert property (@(posedge vclk) disable iff (rst_i)
		irq_i |-> (irqEn_i && ($countones(colBits_i) > 1)))
	else begin
		failCount++;
		$error("irq_o high without its enable or without a two sprite collision");
	end

	// blanked input comes out as zero after the pipeline
	assert property (@(posedge vclk) disable iff (rst_i)
		blank_i |-> ##PIPE_DEPTH (zrgb_i == '0))
	else begin
		failCount++;
		$error("zrgb_o not zero for a blanked input");
	end

endmodule

bind spriteController spriteControllerChk spriteControllerChk_i (
	.vclk(vclk),
	.rst_i(rst_i),
	.regRd_i(regRd_i),
	.rdValid_i(rdValid_o),
	.irq_i(irq_o),
	.irqEn_i(irqEn),
	.colBits_i(colBits),
	.blank_i(blank_i),
	.zrgb_i(zrgb_o)
);

`default_nettype wire

// ==== verification/spriteControllerTb.sv ====
`default_nettype none

module spriteControllerTb;
	timeunit 1ns;
	timeprecision 1ps;
	import spritePkg::*;

	localparam int DRIVE_DLY = 10;
	// raster of 80 cycle lines with horizontal blanking at the end
	localparam int LINE_LEN = 80;
	localparam int H_ACTIVE = 76;
	localparam int NUM_LINES = 40;
	// vsync cycle plus the lines plus the drain
	localparam int FRAME_CYCLES = 1 + LINE_LEN * NUM_LINES + PIPE_DEPTH;
	localparam int MAX_CYCLES = 10 * FRAME_CYCLES + 2000;

	logic vclk;
	logic rst_i;
	logic hsync_i;
	logic vsync_i;
	logic blank_i;
	logic [ZRGB_W-1:0] zrgb_i;
	logic [ZRGB_W-1:0] zrgb_o;
	logic regWe_i;
	logic regRd_i;
	logic [REG_ADR_W-1:0] regAdr_i;
	logic [REG_DAT_W-1:0] regWdata_i;
	logic [REG_DAT_W-1:0] rdData_o;
	logic rdValid_o;
	logic imgWe_i;
	logic [SPR_IDX_W-1:0] imgSprite_i;
	logic [IMG_ADR_W-1:0] imgAdr_i;
	logic [PIX_W-1:0] imgDat_i;
	logic irq_o;

	// model state mirrors what was written to the DUT
	int sprHPos [NUM_SPRITES];
	int sprVPos [NUM_SPRITES];
	int sprW [NUM_SPRITES];
	int sprH [NUM_SPRITES];
	int sprHs [NUM_SPRITES];
	int sprVs [NUM_SPRITES];
	logic [PLANE_W-1:0] sprPlane [NUM_SPRITES];
	logic [PIX_W-1:0] sprTc [NUM_SPRITES];
	logic [NUM_SPRITES-1:0] sprEnM;
	logic [PIX_W-1:0] imgMem [NUM_SPRITES][2**IMG_ADR_W];
	logic [NUM_SPRITES-1:0] colModel;
	logic pendModel;
	// expected outputs still in the pipeline
	logic [ZRGB_W-1:0] expQ [$];
	int cycleCount = 0;

	spriteController spriteController_i (
		.vclk, .rst_i, .hsync_i, .vsync_i, .blank_i, .zrgb_i, .zrgb_o,
		.regWe_i, .regRd_i, .regAdr_i, .regWdata_i, .rdData_o, .rdValid_o,
		.imgWe_i, .imgSprite_i, .imgAdr_i, .imgDat_i, .irq_o
	);

	initial begin
		vclk = 1'b0;
		forever #50 vclk = ~vclk;
	end

	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1, "run stopped");
	endtask

	// watchdog and bound assertion monitor
	always @(posedge vclk) begin
		cycleCount++;
		if (spriteController_i.spriteControllerChk_i.failCount != 0) begin
			abortRun("a bound assertion failed");
		end else if (cycleCount >= MAX_CYCLES) begin
			abortRun("timeout, the tests did not finish within the cycle limit");
		end
	end

	task automatic checkEq(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (act !== exp) begin
			abortRun($sformatf("FAIL %0t %s expected %h actual %h", $time, name, exp, act));
		end
	endtask

	task automatic nextCycle();
		@(posedge vclk);
		#DRIVE_DLY;
	endtask

	// ----------------------------------------------------------
	// host port
	// ----------------------------------------------------------
	task automatic regWrite(input int adr, input logic [REG_DAT_W-1:0] data);
		nextCycle();
		regWe_i = 1'b1;
		regAdr_i = REG_ADR_W'(adr);
		regWdata_i = data;
		nextCycle();
		regWe_i = 1'b0;
	endtask

	// data is due exactly one cycle after the request
	task automatic regRead(input int adr, output logic [REG_DAT_W-1:0] data);
		nextCycle();
		regRd_i = 1'b1;
		regAdr_i = REG_ADR_W'(adr);
		nextCycle();
		regRd_i = 1'b0;
		checkEq("rdValid_o", 64'd1, {63'd0, rdValid_o});
		data = rdData_o;
	endtask

	task automatic checkRead(input int adr, input logic [REG_DAT_W-1:0] exp);
		logic [REG_DAT_W-1:0] d;
		regRead(adr, d);
		checkEq($sformatf("rdData_o[adr %0d]", adr), exp, d);
	endtask

	task automatic setSprite(input int i, input int hp, input int vp, input int w, input int h,
		input int hs, input int vs, input int pl, input logic [PIX_W-1:0] tc);
		regWrite(i * 4 + REG_POS, (vp << 16) | hp);
		regWrite(i * 4 + REG_SIZE, (pl << 24) | (vs << 20) | (hs << 16) | (h << 8) | w);
		regWrite(i * 4 + REG_TC, tc);
		sprHPos[i] = hp;
		sprVPos[i] = vp;
		sprW[i] = w;
		sprH[i] = h;
		sprHs[i] = hs;
		sprVs[i] = vs;
		sprPlane[i] = PLANE_W'(pl);
		sprTc[i] = tc;
	endtask

	task automatic setEnable(input logic [NUM_SPRITES-1:0] mask);
		regWrite(REG_EN, mask);
		sprEnM = mask;
	endtask

	// random images with about a quarter transparent
	task automatic loadImages();
		logic [PIX_W-1:0] d;
		for (int s = 0; s < NUM_SPRITES; s++) begin
			for (int a = 0; a < 2**IMG_ADR_W; a++) begin
				nextCycle();
				d = (($urandom() % 4) == 0) ? sprTc[s] : PIX_W'($urandom());
				imgWe_i = 1'b1;
				imgSprite_i = SPR_IDX_W'(s);
				imgAdr_i = IMG_ADR_W'(a);
				imgDat_i = d;
				imgMem[s][a] = d;
			end
		end
		nextCycle();
		imgWe_i = 1'b0;
	endtask

	// ----------------------------------------------------------
	// reference model and stream driver
	// ----------------------------------------------------------
	function automatic logic [ZRGB_W-1:0] randomZrgb();
		logic [63:0] r;
		r = {$urandom(), $urandom()};
		return r[ZRGB_W-1:0];
	endfunction

	function automatic logic [ZRGB_W-1:0] expectPixel(input int x, input int y,
		input logic [ZRGB_W-1:0] zin, input logic bl, output logic [NUM_SPRITES-1:0] act);
		int dx;
		int dy;
		int win;
		logic [PIX_W-1:0] p;
		logic [PIX_W-1:0] winPix;
		act = '0;
		win = -1;
		winPix = '0;
		for (int i = 0; i < NUM_SPRITES; i++) begin
			dx = x - sprHPos[i];
			dy = y - sprVPos[i];
			// covered area is size times pixel size in each direction
			if (sprEnM[i] && dx >= 0 && dx < (sprW[i] + 1) * (sprHs[i] + 1)
				&& dy >= 0 && dy < (sprH[i] + 1) * (sprVs[i] + 1)) begin
				p = imgMem[i][(dy / (sprVs[i] + 1)) * (sprW[i] + 1) + dx / (sprHs[i] + 1)];
				if (p != sprTc[i]) begin
					act[i] = 1'b1;
					// lowest index seen first wins
					if (win < 0) begin
						win = i;
						winPix = p;
					end
				end
			end
		end
		if (bl) begin
			return '0;
		end else if (win >= 0 && zin[ZRGB_W-1 -: PLANE_W] <= sprPlane[win]) begin
			return {sprPlane[win], winPix[7:5], 9'd0, winPix[4:2], 9'd0, winPix[1:0], 10'd0};
		end else begin
			return zin;
		end
	endfunction

	// output of four cycles ago is checked before the new drive
	task automatic streamCycle(input logic hs, input logic vs, input logic bl,
		input logic [ZRGB_W-1:0] z, input logic [ZRGB_W-1:0] exp);
		nextCycle();
		if (expQ.size() == PIPE_DEPTH) begin
			checkEq("zrgb_o", expQ.pop_front(), zrgb_o);
		end
		hsync_i = hs;
		vsync_i = vs;
		blank_i = bl;
		zrgb_i = z;
		expQ.push_back(exp);
	endtask

	task automatic runFrame(input int blankLo, input int blankHi);
		logic [ZRGB_W-1:0] z;
		logic [ZRGB_W-1:0] e;
		logic [NUM_SPRITES-1:0] act;
		logic bl;
		// blanked vsync cycle
		streamCycle(1'b0, 1'b1, 1'b1, randomZrgb(), '0);
		for (int y = 0; y < NUM_LINES; y++) begin
			for (int x = 0; x < LINE_LEN; x++) begin
				z = randomZrgb();
				bl = (x >= H_ACTIVE) || (x >= blankLo && x < blankHi);
				e = expectPixel(x, y, z, bl, act);
				// two or more active sprites collide even when blanked
				if ($countones(act) > 1) begin
					colModel = colModel | act;
					pendModel = 1'b1;
				end
				streamCycle(x == 0, 1'b0, bl, z, e);
			end
		end
		// drain
		while (expQ.size() != 0) begin
			nextCycle();
			checkEq("zrgb_o", expQ.pop_front(), zrgb_o);
			hsync_i = 1'b0;
			blank_i = 1'b1;
		end
	endtask

	// ----------------------------------------------------------
	// directed tests
	// ----------------------------------------------------------
	task automatic testRegReadback();
		logic [REG_DAT_W-1:0] wr [16];
		logic [REG_DAT_W-1:0] mask;
		logic [REG_DAT_W-1:0] en;
		logic [REG_DAT_W-1:0] ie;
		for (int a = 0; a < 16; a++) begin
			wr[a] = $urandom();
			regWrite(a, wr[a]);
		end
		for (int a = 0; a < 16; a++) begin
			case (a % 4)
				0: mask = 32'h0FFF_0FFF;
				1: mask = 32'h0FFF_0F0F;
				2: mask = 32'h0000_00FF;
				default: mask = '0;
			endcase
			checkRead(a, wr[a] & mask);
		end
		en = $urandom();
		ie = $urandom();
		regWrite(REG_EN, en);
		regWrite(REG_IE, ie);
		// collision and status ignore writes
		regWrite(REG_COL, '1);
		regWrite(REG_STAT, '1);
		checkRead(REG_EN, en & 32'hF);
		checkRead(REG_IE, ie & 32'h1);
		checkRead(REG_COL, '0);
		checkRead(REG_STAT, '0);
		for (int a = 20; a < 32; a++) begin
			checkRead(a, '0);
		end
		regWrite(REG_IE, '0);
		setEnable('0);
	endtask

	task automatic testSingleSprite();
		setSprite(0, 5, 2, 15, 15, 0, 0, 15, PIX_W'($urandom()));
		setSprite(1, 10, 3, 7, 4, 3, 2, 15, PIX_W'($urandom()));
		// starts on the hsync cycle itself
		setSprite(2, 0, 0, 3, 2, 15, 11, 15, PIX_W'($urandom()));
		// runs into the horizontal blanking up to the last cycle of the line
		setSprite(3, 60, 20, 9, 5, 1, 2, 15, PIX_W'($urandom()));
		loadImages();
		for (int k = 0; k < NUM_SPRITES; k++) begin
			setEnable(NUM_SPRITES'(1 << k));
			runFrame(0, 0);
		end
	endtask

	// sprite 0 disabled under sprite 1
	task automatic testTransparency();
		setSprite(0, 20, 5, 15, 15, 1, 0, 15, sprTc[0]);
		setSprite(1, 30, 8, 15, 15, 0, 0, 15, sprTc[1]);
		setEnable(4'b0010);
		runFrame(0, 0);
	endtask

	task automatic testPriority();
		for (int i = 0; i < NUM_SPRITES; i++) begin
			setSprite(i, 10 + 4 * i, 4 + 2 * i, 7, 7, 1, 1, 15, sprTc[i]);
		end
		setEnable(4'hF);
		runFrame(0, 0);
		// stream in front of some sprites
		for (int i = 0; i < NUM_SPRITES; i++) begin
			setSprite(i, 10 + 4 * i, 4 + 2 * i, 7, 7, 1, 1, 2 + 4 * i, sprTc[i]);
		end
		runFrame(0, 0);
	endtask

	task automatic testCollision();
		regWrite(REG_IE, '0);
		// earlier frames left their own collisions
		checkRead(REG_STAT, pendModel);
		checkRead(REG_COL, colModel);
		colModel = '0;
		pendModel = 1'b0;
		checkRead(REG_STAT, '0);
		setSprite(1, 30, 10, 15, 7, 0, 1, 15, sprTc[1]);
		setSprite(2, 38, 14, 15, 7, 0, 1, 15, sprTc[2]);
		setEnable(4'b0110);
		runFrame(0, 0);
		if (colModel != 4'b0110) begin
			abortRun("overlapping sprites 1 and 2 produced no collision in the model");
		end
		checkRead(REG_STAT, 32'd1);
		checkEq("irq_o", 64'd0, {63'd0, irq_o});
		regWrite(REG_IE, 32'd1);
		checkEq("irq_o", 64'd1, {63'd0, irq_o});
		// read clears bits and pending
		checkRead(REG_COL, colModel);
		colModel = '0;
		pendModel = 1'b0;
		checkEq("irq_o", 64'd0, {63'd0, irq_o});
		checkRead(REG_COL, '0);
		checkRead(REG_STAT, '0);
	endtask

	// blank window cuts through sprite 0
	task automatic testBlanking();
		setSprite(0, 4, 2, 15, 15, 1, 1, 15, sprTc[0]);
		setEnable(4'b0001);
		runFrame(8, 40);
	endtask

	initial begin
		void'($urandom(50959));
		rst_i = 1'b1;
		hsync_i = 1'b0;
		vsync_i = 1'b0;
		blank_i = 1'b0;
		zrgb_i = '0;
		regWe_i = 1'b0;
		regRd_i = 1'b0;
		regAdr_i = '0;
		regWdata_i = '0;
		imgWe_i = 1'b0;
		imgSprite_i = '0;
		imgAdr_i = '0;
		imgDat_i = '0;
		sprEnM = '0;
		colModel = '0;
		pendModel = 1'b0;
		repeat (16) nextCycle();
		rst_i = 1'b0;

		testRegReadback();
		testSingleSprite();
		testTransparency();
		testPriority();
		testCollision();
		testBlanking();

		nextCycle();
		if (spriteController_i.spriteControllerChk_i.failCount == 0) begin
			$display("Simulation passed");
			$finish;
		end else begin
			abortRun("a bound assertion failed");
		end
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
design/spritePkg.sv
design/spriteRegs.sv
design/spriteImageRam.sv
design/spriteEngine.sv
design/spriteCompositor.sv
design/spriteController.sv
verification/spriteController_chk.sv
verification/spriteControllerTb.sv

// ==== Bender.yml ====
package:
  name: sprite_controller

sources:
  - design/spritePkg.sv
  - design/spriteRegs.sv
  - design/spriteImageRam.sv
  - design/spriteEngine.sv
  - design/spriteCompositor.sv
  - design/spriteController.sv
  - target: test
    files:
      - verification/spriteController_chk.sv
      - verification/spriteControllerTb.sv
